/* common/video_pkg.sv */
package video_pkg;

   ////////////////////////////////////////
   // 1024 x 768 @ 60 Hz raster

   // horizontal, in pixel clocks
   localparam int h_active = 1024;
   localparam int h_front  = 24;
   localparam int h_sync   = 136;
   localparam int h_back   = 160;
   localparam int h_total  = 1344;   // sum of the four above

   // vertical, in lines
   localparam int v_active = 768;
   localparam int v_front  = 3;
   localparam int v_sync   = 6;
   localparam int v_back   = 29;
   localparam int v_total  = 806;

   ////////////////////////////////////////
   // counter and pixel types

   typedef logic [10:0] hcount_t;   // pixel on current line
   typedef logic [9:0]  vcount_t;   // line in frame

   // r in [11:8], g in [7:4], b in [3:0]
   typedef logic [11:0] pixel_t;

   ////////////////////////////////////////
   // colours

   // white is the neutral element when shapes are ANDed together
   localparam pixel_t color_white    = 12'hFFF;
   localparam pixel_t color_black    = 12'h000;
   localparam pixel_t color_key_band = 12'hCCC;   // light grey

endpackage

/* common/note_pkg.sv */
package note_pkg;

   import video_pkg::*;

   ////////////////////////////////////////
   // notes

   typedef logic [6:0] note_t;   // midi style note number

   // keys that get drawn
   localparam note_t note_lowest  = 7'd36;
   localparam note_t note_highest = 7'd96;

   // demo run, climbs one note at a time and wraps
   localparam note_t run_first   = 7'd40;
   localparam note_t run_last    = 7'd84;
   localparam note_t run_restart = 7'd36;

   // queue contents after reset, slot 0 first
   // 127 sits off the keyboard so slot 0 starts empty
   localparam note_t queue_init [5] = '{7'd127, 7'd72, 7'd37, 7'd38, 7'd39};

   ////////////////////////////////////////
   // key and bar geometry

   typedef logic [10:0] key_x_t;   // same width as hcount_t

   localparam key_x_t key_pitch = 11'd17;   // linear layout, x = (note - lowest) * pitch

   localparam key_x_t  bar_width  = 11'd10;
   localparam vcount_t bar_height = 10'd160;
   localparam pixel_t  color_bar  = 12'h00F;   // blue

   localparam vcount_t key_band_top  = 10'd640;
   localparam vcount_t learn_bar_top = 10'd480;   // bar ends right on the band

   // falling bar start lines, slot 0 lowest on screen
   // 10 bit so slot 4 starts above the frame and wraps in
   localparam vcount_t slot_start_y [5] = '{10'd480, 10'd320, 10'd160, 10'd0, 10'd864};

   localparam vcount_t step_pixels = 10'd2;   // fall per movement step

   ////////////////////////////////////////
   // screens

   typedef enum logic {
      mode_learn,
      mode_game
   } display_mode_t;

endpackage

/* video/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing import video_pkg::*; (
   input  logic    pixel_clk_in,
   input  logic    reset_in,
   output hcount_t hcount,    // pixel on line
   output vcount_t vcount,    // line in frame
   output logic    hsync,     // active high here
   output logic    vsync,     // active high here
   output logic    blank      // high outside 1024 x 768
);

   ////////////////////////////////////////
   // compare points

   logic h_blank_on;   // last active pixel
   logic h_sync_on;
   logic h_sync_off;
   logic h_reset;      // last pixel of line
   logic v_blank_on;
   logic v_sync_on;
   logic v_sync_off;
   logic v_reset;      // last pixel of frame

   logic h_blank;
   logic v_blank;
   logic next_h_blank;
   logic next_v_blank;

   assign h_blank_on = (hcount == hcount_t'(h_active - 1));                       // 1023
   assign h_sync_on  = (hcount == hcount_t'(h_active + h_front - 1));             // 1047
   assign h_sync_off = (hcount == hcount_t'(h_active + h_front + h_sync - 1));    // 1183
   assign h_reset    = (hcount == hcount_t'(h_total - 1));                        // 1343

   // vertical edges only on the last pixel of a line
   assign v_blank_on = h_reset & (vcount == vcount_t'(v_active - 1));             // 767
   assign v_sync_on  = h_reset & (vcount == vcount_t'(v_active + v_front - 1));   // 770
   assign v_sync_off = h_reset & (vcount == vcount_t'(v_active + v_front + v_sync - 1));
   assign v_reset    = h_reset & (vcount == vcount_t'(v_total - 1));              // 805

   assign next_h_blank = h_reset ? 1'b0 : (h_blank_on ? 1'b1 : h_blank);
   assign next_v_blank = v_reset ? 1'b0 : (v_blank_on ? 1'b1 : v_blank);

   ////////////////////////////////////////
   // counters, sync and blank registers

   always_ff @(posedge pixel_clk_in) begin
      if (reset_in) begin
         hcount  <= '0;
         vcount  <= '0;
         h_blank <= 1'b0;
         v_blank <= 1'b0;
         hsync   <= 1'b0;
         vsync   <= 1'b0;
         blank   <= 1'b0;
      end else begin
         hcount  <= h_reset ? '0 : hcount + 1'b1;
         if (h_reset) begin
            vcount <= v_reset ? '0 : vcount + 1'b1;   // one line per wrap
         end
         h_blank <= next_h_blank;
         v_blank <= next_v_blank;
         hsync   <= h_sync_on ? 1'b1 : (h_sync_off ? 1'b0 : hsync);
         vsync   <= v_sync_on ? 1'b1 : (v_sync_off ? 1'b0 : vsync);
         // h part drops on the wrap so the next line starts unblanked
         blank   <= next_v_blank | next_h_blank;
      end
   end

   // counter wraps before it can hit the total
   a_hcount_range : assert property (@(posedge pixel_clk_in) disable iff (reset_in)
      hcount < hcount_t'(h_total));

   // vsync edges line up with the start of a line
   a_vsync_line_edge : assert property (@(posedge pixel_clk_in) disable iff (reset_in)
      $changed(vsync) |-> (hcount == '0));

endmodule

/* notes/note_sequencer.sv */
`timescale 1ns/1ps

module note_sequencer import note_pkg::*; #(
   parameter int cycles_per_note = 16250000   // period minus one
) (
   input  logic  pixel_clk_in,
   input  logic  reset_in,
   output note_t note_slot_0,   // oldest
   output note_t note_slot_1,
   output note_t note_slot_2,
   output note_t note_slot_3,
   output note_t note_slot_4,   // newest
   output logic  new_note       // one cycle, same edge as the shift
);

   localparam int note_count_w = $clog2(cycles_per_note + 1);

   logic [note_count_w-1:0] note_count;
   logic                    note_due;     // last cycle of the period
   note_t                   next_note;    // next note of the run
   note_t                   queue [5];

   ////////////////////////////////////////
   // note period

   assign note_due = (note_count == note_count_w'(cycles_per_note));

   always_ff @(posedge pixel_clk_in) begin
      if (reset_in) begin
         note_count <= '0;
         new_note   <= 1'b0;
      end else begin
         note_count <= note_due ? '0 : note_count + 1'b1;
         new_note   <= note_due;   // lands with the shift below
      end
   end

   ////////////////////////////////////////
   // run generator and queue

   always_ff @(posedge pixel_clk_in) begin
      if (reset_in) begin
         next_note <= run_first;
         queue     <= queue_init;
      end else if (note_due) begin
         // run climbs by one, back to the restart note after the last
         next_note <= (next_note == run_last) ? run_restart : next_note + 1'b1;
         for (int i = 0; i < 4; i++) begin
            queue[i] <= queue[i+1];   // everyone moves down a slot
         end
         queue[4] <= next_note;
      end
   end

   assign note_slot_0 = queue[0];
   assign note_slot_1 = queue[1];
   assign note_slot_2 = queue[2];
   assign note_slot_3 = queue[3];
   assign note_slot_4 = queue[4];

   // renderer resets bar positions on each pulse, two in a row would hide a step
   a_new_note_single : assert property (@(posedge pixel_clk_in) disable iff (reset_in)
      new_note |=> !new_note);

endmodule

/* hdl/note_renderer.sv */
`timescale 1ns/1ps

module note_renderer import video_pkg::*, note_pkg::*; #(
   parameter int cycles_per_step = 203125   // step period minus one
) (
   input  logic          pixel_clk_in,
   input  logic          reset_in,
   input  display_mode_t mode,
   input  note_t         learning_note,
   input  hcount_t       hcount,
   input  vcount_t       vcount,
   input  logic          hsync,
   input  logic          vsync,
   input  logic          blank,
   input  note_t         note_slot_0,
   input  note_t         note_slot_1,
   input  note_t         note_slot_2,
   input  note_t         note_slot_3,
   input  note_t         note_slot_4,
   input  logic          new_note,
   output pixel_t        pixel,
   output logic          pixel_hsync,
   output logic          pixel_vsync,
   output logic          pixel_blank
);

   localparam int step_count_w = $clog2(cycles_per_step + 1);

   logic [step_count_w-1:0] step_count;
   logic                    step_due;
   vcount_t                 bar_y [5];    // top line of each falling bar
   note_t                   slots [5];
   pixel_t                  band_pixel;
   pixel_t                  learn_pixel;
   pixel_t                  game_pixel;
   pixel_t                  next_pixel;

   ////////////////////////////////////////
   // key x and bar hit test

   function automatic key_x_t key_x_of(note_t note);
      key_x_t offset;
      offset = key_x_t'(note) - key_x_t'(note_lowest);
      return offset * key_pitch;   // linear layout
   endfunction

   function automatic logic on_keys(note_t note);
      return (note >= note_lowest) && (note <= note_highest);
   endfunction

   // 11 bit bottom so a bar near the top of the range does not wrap onto the screen
   function automatic logic bar_hit(note_t note, vcount_t top, hcount_t h, vcount_t v);
      key_x_t      left;
      logic [10:0] bottom;   // one past the last line
      left   = key_x_of(note);
      bottom = {1'b0, top} + {1'b0, bar_height};
      return on_keys(note) && (h >= left) && (h < left + bar_width) &&
             ({1'b0, v} >= {1'b0, top}) && ({1'b0, v} < bottom);
   endfunction

   assign slots = '{note_slot_0, note_slot_1, note_slot_2, note_slot_3, note_slot_4};

   ////////////////////////////////////////
   // bar movement

   assign step_due = (step_count == step_count_w'(cycles_per_step));

   always_ff @(posedge pixel_clk_in) begin
      if (reset_in) begin
         step_count <= '0;
         bar_y      <= slot_start_y;
      end else begin
         step_count <= step_due ? '0 : step_count + 1'b1;
         if (new_note) begin
            bar_y <= slot_start_y;   // queue just shifted, start over
         end else if (step_due) begin
            for (int i = 0; i < 5; i++) begin
               bar_y[i] <= bar_y[i] + step_pixels;   // wraps at 1024
            end
         end
      end
   end

   ////////////////////////////////////////
   // screen composition

   always_comb begin
      // each shape is white where it does not cover
      band_pixel  = (vcount >= key_band_top) ? color_key_band : color_white;
      learn_pixel = bar_hit(learning_note, learn_bar_top, hcount, vcount) ?
                    color_bar : color_white;
      game_pixel  = color_white;
      for (int i = 0; i < 5; i++) begin
         if (bar_hit(slots[i], bar_y[i], hcount, vcount)) begin
            game_pixel = game_pixel & color_bar;
         end
      end
      if (mode == mode_learn) begin
         next_pixel = band_pixel & learn_pixel;
      end else begin
         // band hides bars that reach into it
         next_pixel = (vcount >= key_band_top) ? color_key_band : game_pixel;
      end
   end

   always_ff @(posedge pixel_clk_in) begin
      pixel <= next_pixel;   // one cycle behind the counters
   end

   // syncs follow the pixel by the same cycle
   always_ff @(posedge pixel_clk_in) begin
      if (reset_in) begin
         pixel_hsync <= 1'b0;
         pixel_vsync <= 1'b0;
         pixel_blank <= 1'b0;
      end else begin
         pixel_hsync <= hsync;
         pixel_vsync <= vsync;
         pixel_blank <= blank;
      end
   end

endmodule

/* hdl/piano_display_top.sv */
`timescale 1ns/1ps

module piano_display_top import video_pkg::*, note_pkg::*; #(
   parameter int cycles_per_note = 16250000,   // about a quarter second at 65 MHz
   parameter int cycles_per_step = 203125
) (
   input  logic          pixel_clk_in,
   input  logic          reset_in,
   input  display_mode_t mode,
   input  note_t         learning_note,
   output logic [3:0]    vga_r,
   output logic [3:0]    vga_g,
   output logic [3:0]    vga_b,
   output logic          vga_hs,   // active low
   output logic          vga_vs    // active low
);

   hcount_t hcount;
   vcount_t vcount;
   logic    hsync;
   logic    vsync;
   logic    blank;
   note_t   note_slot_0;
   note_t   note_slot_1;
   note_t   note_slot_2;
   note_t   note_slot_3;
   note_t   note_slot_4;
   logic    new_note;
   pixel_t  pixel;
   logic    pixel_hsync;
   logic    pixel_vsync;
   logic    pixel_blank;
   pixel_t  rgb;        // gated colour

   ////////////////////////////////////////
   // raster, notes, picture

   vga_timing u_timing (
      .pixel_clk_in (pixel_clk_in),
      .reset_in     (reset_in),
      .hcount       (hcount),
      .vcount       (vcount),
      .hsync        (hsync),
      .vsync        (vsync),
      .blank        (blank)
   );

   note_sequencer #(.cycles_per_note(cycles_per_note)) u_sequencer (
      .pixel_clk_in (pixel_clk_in),
      .reset_in     (reset_in),
      .note_slot_0  (note_slot_0),
      .note_slot_1  (note_slot_1),
      .note_slot_2  (note_slot_2),
      .note_slot_3  (note_slot_3),
      .note_slot_4  (note_slot_4),
      .new_note     (new_note)
   );

   note_renderer #(.cycles_per_step(cycles_per_step)) u_renderer (
      .pixel_clk_in  (pixel_clk_in),
      .reset_in      (reset_in),
      .mode          (mode),
      .learning_note (learning_note),
      .hcount        (hcount),
      .vcount        (vcount),
      .hsync         (hsync),
      .vsync         (vsync),
      .blank         (blank),
      .note_slot_0   (note_slot_0),
      .note_slot_1   (note_slot_1),
      .note_slot_2   (note_slot_2),
      .note_slot_3   (note_slot_3),
      .note_slot_4   (note_slot_4),
      .new_note      (new_note),
      .pixel         (pixel),
      .pixel_hsync   (pixel_hsync),
      .pixel_vsync   (pixel_vsync),
      .pixel_blank   (pixel_blank)
   );

   ////////////////////////////////////////
   // output stage, second cycle of lag

   always_ff @(posedge pixel_clk_in) begin
      if (reset_in) begin
         rgb    <= color_black;
         vga_hs <= 1'b1;   // idle high on the connector
         vga_vs <= 1'b1;
      end else begin
         rgb    <= pixel_blank ? color_black : pixel;   // black in blanking
         vga_hs <= ~pixel_hsync;
         vga_vs <= ~pixel_vsync;
      end
   end

   assign vga_r = rgb[11:8];
   assign vga_g = rgb[7:4];
   assign vga_b = rgb[3:0];

endmodule

/* verification/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import video_pkg::*, note_pkg::*; #(
   parameter int cycles_per_note = 40000,
   parameter int cycles_per_step = 3000
) (
   input  logic          pixel_clk_in,
   input  logic          reset_in,
   input  display_mode_t mode,
   input  note_t         learning_note,
   input  logic [3:0]    vga_r,
   input  logic [3:0]    vga_g,
   input  logic [3:0]    vga_b,
   input  logic          vga_hs,
   input  logic          vga_vs,
   output int            check_count,
   output int            error_count
);

   localparam int max_printed = 20;

   int checks = 0;
   int errors = 0;
   bit edge_reset = 1'b0;   // reset_in as taken by the last rising edge
   bit model_ok = 1'b0;

   // model registers, same values the DUT holds between edges
   int h;
   int v;
   int note_cnt;
   int step_cnt;
   bit pulse;               // new_note
   int run_note;
   int queue_m [5];
   int bar_top [5];

   // expected outputs, stage 1 lands on the pins at the next edge
   bit          exp_ok [2] = '{1'b0, 1'b0};
   logic [11:0] exp_rgb [2];
   logic        exp_hs [2];
   logic        exp_vs [2];
   int          exp_h [2];
   int          exp_v [2];

   // sync edge times in cycles
   int   cyc = 0;
   logic hs_prev = 1'b1;
   logic vs_prev = 1'b1;
   int   hs_fall = -1;
   int   vs_fall = -1;

   assign check_count = checks;
   assign error_count = errors;

   ////////////////////////////////////////
   // reporting

   task automatic report_mismatch(string msg);
      errors++;
      if (errors <= max_printed)
         $display("mismatch at %0t: %s", $time, msg);
      else if (errors == max_printed + 1)
         $display("more mismatches follow, only counted from here");
   endtask

   ////////////////////////////////////////
   // screen rules

   function automatic bit bar_covers(int note, int top, int px, int ln);
      int left;
      left = (note - int'(note_lowest)) * int'(key_pitch);   // linear keys
      if (note < int'(note_lowest) || note > int'(note_highest))
         return 1'b0;   // off the keyboard
      return px >= left && px < left + int'(bar_width) &&
             ln >= top && ln < top + int'(bar_height);
   endfunction

   function automatic logic [11:0] screen_color(int px, int ln);
      logic [11:0] c;
      c = color_white;
      if (ln >= int'(key_band_top)) begin
         c = color_key_band;   // band wins in both modes
      end else if (mode == mode_learn) begin
         if (bar_covers(int'(learning_note), int'(learn_bar_top), px, ln))
            c = color_bar;
      end else begin
         for (int i = 0; i < 5; i++) begin
            if (bar_covers(queue_m[i], bar_top[i], px, ln))
               c = color_bar;
         end
      end
      return c;
   endfunction

   ////////////////////////////////////////
   // model state

   task automatic reset_model();
      h        = 0;
      v        = 0;
      note_cnt = 0;
      step_cnt = 0;
      pulse    = 1'b0;
      run_note = int'(run_first);
      for (int i = 0; i < 5; i++) begin
         queue_m[i] = int'(queue_init[i]);
         bar_top[i] = int'(slot_start_y[i]);
      end
   endtask

   // one rising edge
   task automatic step_model();
      bit note_due;
      bit step_due;
      note_due = (note_cnt == cycles_per_note);
      step_due = (step_cnt == cycles_per_step);
      for (int i = 0; i < 5; i++) begin
         if (pulse)
            bar_top[i] = int'(slot_start_y[i]);   // pulse from the edge before
         else if (step_due)
            bar_top[i] = (bar_top[i] + int'(step_pixels)) % 1024;
      end
      if (note_due) begin
         for (int i = 0; i < 4; i++)
            queue_m[i] = queue_m[i+1];
         queue_m[4] = run_note;
         run_note   = (run_note == int'(run_last)) ? int'(run_restart) : run_note + 1;
      end
      pulse    = note_due;
      note_cnt = note_due ? 0 : note_cnt + 1;
      step_cnt = step_due ? 0 : step_cnt + 1;
      if (h == h_total - 1) begin
         h = 0;
         v = (v == v_total - 1) ? 0 : v + 1;
      end else begin
         h = h + 1;
      end
   endtask

   task automatic load_expected();
      bit blank_m;
      blank_m    = (h >= h_active) || (v >= v_active);
      exp_ok[0]  = model_ok;
      exp_h[0]   = h;
      exp_v[0]   = v;
      exp_rgb[0] = blank_m ? color_black : screen_color(h, v);
      exp_hs[0]  = !(h >= h_active + h_front && h < h_active + h_front + h_sync);
      exp_vs[0]  = !(v >= v_active + v_front && v < v_active + v_front + v_sync);
   endtask

   ////////////////////////////////////////
   // comparing

   task automatic check_syncs();
      if (hs_prev && !vga_hs) begin
         checks++;
         if (hs_fall >= 0 && cyc - hs_fall != h_total)
            report_mismatch($sformatf("vga_hs falls %0d cycles apart, expected %0d",
                                      cyc - hs_fall, h_total));
         hs_fall = cyc;
      end
      if (!hs_prev && vga_hs) begin
         checks++;
         if (cyc - hs_fall != h_sync)
            report_mismatch($sformatf("vga_hs low for %0d cycles, expected %0d",
                                      cyc - hs_fall, h_sync));
      end
      if (vs_prev && !vga_vs) begin
         checks++;
         if (vs_fall >= 0 && cyc - vs_fall != v_total * h_total)
            report_mismatch($sformatf("vga_vs falls %0d cycles apart, expected %0d",
                                      cyc - vs_fall, v_total * h_total));
         vs_fall = cyc;
      end
      if (!vs_prev && vga_vs) begin
         checks++;
         if (cyc - vs_fall != v_sync * h_total)
            report_mismatch($sformatf("vga_vs low for %0d cycles, expected %0d",
                                      cyc - vs_fall, v_sync * h_total));
      end
      hs_prev = vga_hs;
      vs_prev = vga_vs;
   endtask

   task automatic compare_outputs();
      logic [11:0] rgb;
      rgb    = {vga_r, vga_g, vga_b};
      checks = checks + 3;
      if (rgb !== exp_rgb[1])
         report_mismatch($sformatf("line %0d pixel %0d colour %h, expected %h",
                                   exp_v[1], exp_h[1], rgb, exp_rgb[1]));
      if (vga_hs !== exp_hs[1])
         report_mismatch($sformatf("line %0d pixel %0d vga_hs %b, expected %b",
                                   exp_v[1], exp_h[1], vga_hs, exp_hs[1]));
      if (vga_vs !== exp_vs[1])
         report_mismatch($sformatf("line %0d pixel %0d vga_vs %b, expected %b",
                                   exp_v[1], exp_h[1], vga_vs, exp_vs[1]));
   endtask

   always @(posedge pixel_clk_in) begin
      edge_reset <= reset_in;
   end

   // outputs settle after the rising edge, so everything is sampled here
   always @(negedge pixel_clk_in) begin
      cyc = cyc + 1;
      if (edge_reset) begin
         reset_model();
         model_ok = 1'b1;
         checks++;
         if (vga_hs !== 1'b1 || vga_vs !== 1'b1 || {vga_r, vga_g, vga_b} !== 12'h000)
            report_mismatch($sformatf("in reset hs %b vs %b colour %h, expected 1 1 000",
                                      vga_hs, vga_vs, {vga_r, vga_g, vga_b}));
      end else begin
         if (model_ok)
            step_model();
         check_syncs();
         if (exp_ok[1])
            compare_outputs();
      end
      exp_ok[1]  = exp_ok[0];
      exp_rgb[1] = exp_rgb[0];
      exp_hs[1]  = exp_hs[0];
      exp_vs[1]  = exp_vs[0];
      exp_h[1]   = exp_h[0];
      exp_v[1]   = exp_v[0];
      load_expected();   // two edges from now on the pins
   end

endmodule

/* verification/tb_top.sv */
`timescale 1ns/1ps

module tb_top import video_pkg::*, note_pkg::*; ();

   localparam int cycles_per_note = 40000;   // short periods so a few frames show motion
   localparam int cycles_per_step = 3000;
   localparam int frame_count     = 3;
   localparam int vs_timeout      = 2 * v_total * h_total;   // two frames of cycles

   logic          pixel_clk_in = 1'b0;
   logic          reset_in;
   display_mode_t mode;
   note_t         learning_note;
   logic [3:0]    vga_r;
   logic [3:0]    vga_g;
   logic [3:0]    vga_b;
   logic          vga_hs;
   logic          vga_vs;
   int            check_count;
   int            error_count;
   logic [31:0]   rng_state;
   bit            timed_out;
   int            tests;
   int            last_checks;
   int            last_errors;

   ////////////////////////////////////////
   // clock, DUT, checker

   always #10 pixel_clk_in = ~pixel_clk_in;   // 20 ns period

   piano_display_top #(
      .cycles_per_note (cycles_per_note),
      .cycles_per_step (cycles_per_step)
   ) i_dut (
      .pixel_clk_in  (pixel_clk_in),
      .reset_in      (reset_in),
      .mode          (mode),
      .learning_note (learning_note),
      .vga_r         (vga_r),
      .vga_g         (vga_g),
      .vga_b         (vga_b),
      .vga_hs        (vga_hs),
      .vga_vs        (vga_vs)
   );

   tb_checker #(
      .cycles_per_note (cycles_per_note),
      .cycles_per_step (cycles_per_step)
   ) i_checker (
      .pixel_clk_in  (pixel_clk_in),
      .reset_in      (reset_in),
      .mode          (mode),
      .learning_note (learning_note),
      .vga_r         (vga_r),
      .vga_g         (vga_g),
      .vga_b         (vga_b),
      .vga_hs        (vga_hs),
      .vga_vs        (vga_vs),
      .check_count   (check_count),
      .error_count   (error_count)
   );

   ////////////////////////////////////////
   // helpers

   // 32 bit xorshift with shifts 13 17 5
   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // vga_vs looked at on falling edges, returns on the next rising edge
   task automatic wait_vs_fall(output bit found);
      int   n;
      logic prev;
      found = 1'b0;
      n     = 0;
      @(negedge pixel_clk_in);
      prev = vga_vs;
      while (!found && n < vs_timeout) begin
         @(negedge pixel_clk_in);
         found = prev & ~vga_vs;
         prev  = vga_vs;
         n++;
      end
      @(posedge pixel_clk_in);
   endtask

   task automatic print_test(string name);
      $display("%s: %0d checks, %0d errors", name,
               check_count - last_checks, error_count - last_errors);
      last_checks = check_count;
      last_errors = error_count;
      tests++;
   endtask

   ////////////////////////////////////////
   // run control

   initial begin
      reset_in      = 1'b1;
      mode          = mode_learn;   // first frame always learn mode
      learning_note = note_t'(60);
      rng_state     = 32'd52;
      timed_out     = 1'b0;
      tests         = 0;
      last_checks   = 0;
      last_errors   = 0;
      repeat (3) @(posedge pixel_clk_in);
      reset_in <= 1'b0;
      @(posedge pixel_clk_in);   // reset outputs seen on the negedges so far
      print_test("reset state");
      for (int f = 0; f < frame_count && !timed_out; f++) begin
         bit found;
         wait_vs_fall(found);
         if (!found) begin
            $display("timeout: vga_vs did not fall within %0d cycles", vs_timeout);
            timed_out = 1'b1;
         end else begin
            print_test($sformatf("frame %0d, %s, learning note %0d", f, mode.name(),
                                 learning_note));
            // new screen for the next frame
            rng_state     = xorshift32(rng_state);
            mode          <= display_mode_t'(rng_state[0]);
            learning_note <= note_t'(30 + rng_state[31:8] % 71);   // 30 to 100
         end
      end
      $display("tests %0d, checks %0d, errors %0d", tests, check_count, error_count);
      if (error_count == 0 && check_count > 0 && !timed_out) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* all.f */
common/video_pkg.sv
common/note_pkg.sv
video/vga_timing.sv
notes/note_sequencer.sv
hdl/note_renderer.sv
hdl/piano_display_top.sv
verification/tb_checker.sv
verification/tb_top.sv

/* Makefile */
# Verilator build and run for the piano display testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
	   echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
